/* common/wbuf_consts.svh */
// Build-time constants of the posted-write buffer
//   queue depth in entries
//   memory size in 32-bit words
//   memory wait states per access

`ifndef WBUF_CONSTS_SVH
`define WBUF_CONSTS_SVH

// Entries in the posted-write queue
`define WBUF_DEPTH 8

// Words in the bus memory, only the low address bits decode
`define WBUF_MEM_WORDS 256

// Cycles the memory waits before it answers
`define WBUF_MEM_WAIT 2

`endif

/* common/wbuf_pkg.sv */
// Shared types of the posted-write buffer
//   bus address and data words
//   queue entry holding one posted write
//   buffer state encoding
//   helpers to pack and unpack a queue entry

`default_nettype none

package wbuf_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Address in the upper half, data in the lower half
	typedef logic [63:0] entry_t;

	typedef enum logic [2:0] {
		IDLE,
		WRITE_TO_QUEUE,
		READ_FROM_BUS,
		DRAIN,
		TERMINATE
	} wbuf_state_t;

	function automatic entry_t make_entry(input addr_t address, input data_t data);
		return {address, data};
	endfunction

	function automatic addr_t entry_address(input entry_t entry);
		return entry[63:32];
	endfunction

	function automatic data_t entry_data(input entry_t entry);
		return entry[31:0];
	endfunction

endpackage

`default_nettype wire

/* write_buffer/wbuf_fifo.sv */
// Synchronous FIFO of posted-write entries
//   register array with read and write pointers
//   occupancy count drives the empty and full flags
//   head entry is presented combinationally

`default_nettype none

module wbuf_fifo #(
	parameter int DEPTH = 4
) (
	input  wire                  i_clock,
	input  wire                  i_reset,
	input  wire                  i_write,
	input  wire wbuf_pkg::entry_t i_wdata,
	input  wire                  i_read,
	output wbuf_pkg::entry_t     o_rdata,
	output logic                 o_empty,
	output logic                 o_full
);
	import wbuf_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t storage [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic push;
	logic pop;

	// Push when full and pop when empty are dropped
	assign push = i_write && !o_full;
	assign pop  = i_read && !o_empty;

	assign o_empty = (count == '0);
	assign o_full  = (count == CNT_W'(DEPTH));
	assign o_rdata = storage[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (push) begin
			storage[wr_ptr] <= i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* write_buffer/write_buffer.sv */
// Posted-write buffer
//   request FSM between the requester port and the memory bus
//   writes are queued and acknowledged at once
//   queued writes drain to the bus in the background
//   reads wait for an empty queue and pass straight through

`default_nettype none

module write_buffer #(
	parameter int DEPTH = 4
) (
	input  wire                 i_clock,
	input  wire                 i_reset,

	// Requester side
	input  wire                 i_request,
	input  wire                 i_rw,
	input  wire wbuf_pkg::addr_t i_address,
	input  wire wbuf_pkg::data_t i_wdata,
	output logic                o_ready,
	output wbuf_pkg::data_t     o_rdata,

	// Queue status
	output logic                o_empty,
	output logic                o_full,

	// Memory bus side
	output logic                o_bus_request,
	output logic                o_bus_rw,
	output wbuf_pkg::addr_t     o_bus_address,
	output wbuf_pkg::data_t     o_bus_wdata,
	input  wire                 i_bus_ready,
	input  wire wbuf_pkg::data_t i_bus_rdata
);
	import wbuf_pkg::*;

	wbuf_state_t state;
	wbuf_state_t next_state;

	logic   q_write;
	entry_t q_wdata;
	logic   q_read;
	entry_t q_rdata;
	logic   q_empty;
	logic   q_full;

	// Entry being written out, captured when it leaves the queue
	entry_t drain_entry;

	logic accept_write;
	logic accept_read;

	wbuf_fifo #(
		.DEPTH(DEPTH)
	) queue0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(q_write),
		.i_wdata(q_wdata),
		.i_read(q_read),
		.o_rdata(q_rdata),
		.o_empty(q_empty),
		.o_full(q_full)
	);

	assign o_empty = q_empty;
	assign o_full  = q_full;

	// Read data comes straight off the bus, valid with o_ready
	assign o_rdata = i_bus_rdata;

	// A write needs room; a read needs every earlier write on the bus
	assign accept_write = i_request && i_rw && !q_full;
	assign accept_read  = i_request && !i_rw && q_empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge i_clock) begin
		if (q_read) begin
			drain_entry <= q_rdata;
		end
	end

	always_comb begin
		next_state = state;

		q_write = 1'b0;
		q_wdata = make_entry(i_address, i_wdata);
		q_read  = 1'b0;

		o_ready = 1'b0;

		o_bus_request = 1'b0;
		o_bus_rw      = 1'b0;
		o_bus_address = '0;
		o_bus_wdata   = '0;

		case (state)
			IDLE: begin
				if (accept_write) begin
					q_write    = 1'b1;
					next_state = WRITE_TO_QUEUE;
				end else if (accept_read) begin
					next_state = READ_FROM_BUS;
				end else if (!q_empty) begin
					// Nothing accepted this cycle, so the bus is free for a drain
					q_read     = 1'b1;
					next_state = DRAIN;
				end
			end

			WRITE_TO_QUEUE: begin
				// Acknowledge until the requester lets go
				o_ready = i_request;
				if (!i_request) begin
					next_state = IDLE;
				end
			end

			READ_FROM_BUS: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b0;
				o_bus_address = i_address;
				o_ready       = i_bus_ready;
				if (i_bus_ready) begin
					next_state = TERMINATE;
				end
			end

			DRAIN: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = entry_address(drain_entry);
				o_bus_wdata   = entry_data(drain_entry);
				if (i_bus_ready) begin
					next_state = TERMINATE;
				end
			end

			TERMINATE: begin
				// One idle bus cycle so the memory sees the access end
				next_state = IDLE;
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/bus_memory.sv */
// Word-addressed RAM on the memory bus
//   fixed number of wait states per access
//   one ready pulse per access, then waits for the request to drop
//   writes land on the ready edge, read data is registered with it

`default_nettype none

`include "wbuf_consts.svh"

module bus_memory (
	input  wire                 i_clock,
	input  wire                 i_reset,
	input  wire                 i_bus_request,
	input  wire                 i_bus_rw,
	input  wire wbuf_pkg::addr_t i_bus_address,
	input  wire wbuf_pkg::data_t i_bus_wdata,
	output logic                o_bus_ready,
	output wbuf_pkg::data_t     o_bus_rdata
);
	import wbuf_pkg::*;

	localparam int MEM_AW = $clog2(`WBUF_MEM_WORDS);
	localparam int CNT_W  = $clog2(`WBUF_MEM_WAIT + 2);

	data_t mem [`WBUF_MEM_WORDS];

	logic [MEM_AW-1:0] index;
	logic [CNT_W-1:0]  wait_count;
	logic              done;
	logic              answer;

	// Word address, upper bits ignored
	assign index = i_bus_address[MEM_AW-1:0];

	// Last wait cycle of an access that has not been answered yet
	assign answer = i_bus_request && !done && (wait_count == CNT_W'(`WBUF_MEM_WAIT));

	initial begin
		for (int i = 0; i < `WBUF_MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count  <= '0;
			done        <= 1'b0;
			o_bus_ready <= 1'b0;
		end else begin
			o_bus_ready <= answer;
			if (!i_bus_request) begin
				// Request dropped, ready for the next access
				wait_count <= '0;
				done       <= 1'b0;
			end else if (answer) begin
				wait_count <= '0;
				done       <= 1'b1;
			end else if (!done) begin
				wait_count <= wait_count + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (answer) begin
			if (i_bus_rw) begin
				mem[index] <= i_bus_wdata;
			end else begin
				o_bus_rdata <= mem[index];
			end
		end
	end

endmodule

`default_nettype wire

/* src/wbuf_top.sv */
// Top level of the posted-write buffer
//   write buffer with its queue on the requester side
//   bus memory as the single bus target
//   bus signals stay internal

`default_nettype none

`include "wbuf_consts.svh"

module wbuf_top (
	input  wire                 i_clock,
	input  wire                 i_reset,
	input  wire                 i_request,
	input  wire                 i_rw,
	input  wire wbuf_pkg::addr_t i_address,
	input  wire wbuf_pkg::data_t i_wdata,
	output wire                 o_ready,
	output wire wbuf_pkg::data_t o_rdata,
	output wire                 o_empty,
	output wire                 o_full
);
	import wbuf_pkg::*;

	logic  bus_request;
	logic  bus_rw;
	addr_t bus_address;
	data_t bus_wdata;
	logic  bus_ready;
	data_t bus_rdata;

	write_buffer #(
		.DEPTH(`WBUF_DEPTH)
	) wbuf0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_empty(o_empty),
		.o_full(o_full),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	bus_memory mem0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_rw(bus_rw),
		.i_bus_address(bus_address),
		.i_bus_wdata(bus_wdata),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

endmodule

`default_nettype wire

/* verif/wbuf_chk.sv */
// Protocol assertions on the posted-write buffer
//   queue flags never both set
//   requester ready only while a request is up
//   bus request held until bus ready
//   bus ready only during a bus request

`default_nettype none

module wbuf_chk (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_ready,
	input wire i_empty,
	input wire i_full,
	input wire i_bus_request,
	input wire i_bus_ready
);

	a_flags_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_full && i_empty))
		else $error("queue reports full and empty together");

	a_ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |-> i_request)
		else $error("o_ready high without a request");

	// Once raised, the bus request waits for the memory
	a_bus_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !i_bus_ready |=> i_bus_request)
		else $error("bus request dropped before bus ready");

	a_bus_ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_ready |-> i_bus_request)
		else $error("bus ready without a bus request");

endmodule

bind wbuf_top wbuf_chk chk0 (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_empty(o_empty),
	.i_full(o_full),
	.i_bus_request(bus_request),
	.i_bus_ready(bus_ready)
);

`default_nettype wire

/* verif/wbuf_tb.sv */
// Testbench of the posted-write buffer
//   clock, reset and a requester driver on the processor-side port
//   memory model updated on each write acknowledge
//   random mix of writes and reads, a burst to fill the queue,
//   a read-back of every address and a final drain check
//   watchdog sized from the number of requests

`default_nettype none

`include "wbuf_consts.svh"

module wbuf_tb;
	import wbuf_pkg::*;

	localparam int NUM_BLANK    = 1;
	localparam int NUM_RANDOM   = 60;
	localparam int NUM_BURST    = `WBUF_DEPTH + 4;
	localparam int NUM_READBACK = 16;
	localparam int NUM_FINAL    = `WBUF_DEPTH;
	localparam int NUM_REQ      = NUM_BLANK + NUM_RANDOM + NUM_BURST + NUM_READBACK + NUM_FINAL;

	// Cycles one request may wait with a full queue to drain first
	localparam int REQ_LIMIT     = (`WBUF_DEPTH + 1) * (`WBUF_MEM_WAIT + 4);
	localparam int EMPTY_LIMIT   = `WBUF_DEPTH * (`WBUF_MEM_WAIT + 4);
	localparam int WATCHDOG_TIME = NUM_REQ * REQ_LIMIT * 20;

	logic  i_clock;
	logic  i_reset;
	logic  i_request;
	logic  i_rw;
	addr_t i_address;
	data_t i_wdata;
	logic  o_ready;
	data_t o_rdata;
	logic  o_empty;
	logic  o_full;

	integer seed = 61589;

	// Expected memory contents and which words were ever written
	data_t model [`WBUF_MEM_WORDS];
	bit    written [`WBUF_MEM_WORDS];

	logic full_seen;

	wbuf_top dut0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_empty(o_empty),
		.o_full(o_full)
	);

	initial begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			abort_run("first mismatch, stopping");
		end
	endtask

	// One request on the requester port held until o_ready
	task automatic issue_request(input logic rw, input addr_t addr, input data_t data,
			input int gap, output data_t rdata);
		int   waited;
		logic full_at_issue;
		repeat (gap) @(posedge i_clock);
		@(negedge i_clock);
		full_at_issue = o_full;
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw      <= rw;
		i_address <= addr;
		i_wdata   <= data;
		waited = 0;
		@(negedge i_clock);
		while (!o_ready) begin
			if (o_full) begin
				full_seen = 1'b1;
			end
			if (waited >= REQ_LIMIT) begin
				abort_run($sformatf("no o_ready within %0d cycles for a request to address %0d",
					REQ_LIMIT, addr));
			end
			waited++;
			@(negedge i_clock);
		end
		if (o_full) begin
			full_seen = 1'b1;
		end
		rdata = o_rdata;
		// With no gap the FSM is back in IDLE and takes a write at once
		if (rw && gap == 0 && !full_at_issue) begin
			check_equal("write_ready_latency", 32'd1, waited);
		end
		if (rw) begin
			model[addr[7:0]]   = data;
			written[addr[7:0]] = 1'b1;
		end
		@(posedge i_clock);
		i_request <= 1'b0;
	endtask

	task automatic write_word(input addr_t addr, input data_t data, input int gap);
		data_t unused_rdata;
		issue_request(1'b1, addr, data, gap, unused_rdata);
	endtask

	task automatic read_and_compare(input addr_t addr, input int gap);
		data_t rdata;
		issue_request(1'b0, addr, '0, gap, rdata);
		if (written[addr[7:0]]) begin
			check_equal("read_data", model[addr[7:0]], rdata);
		end else begin
			check_equal("read_unwritten", 32'd0, rdata);
		end
	endtask

	initial begin
		#(WATCHDOG_TIME);
		abort_run("watchdog expired before the test sequence completed");
	end

	initial begin
		logic [31:0] r;
		data_t       d;
		addr_t       a;
		int          gap;
		int          waited;
		i_reset   = 1'b1;
		i_request = 1'b0;
		i_rw      = 1'b0;
		i_address = '0;
		i_wdata   = '0;
		full_seen = 1'b0;
		for (int k = 0; k < `WBUF_MEM_WORDS; k++) begin
			model[k]   = '0;
			written[k] = 1'b0;
		end

		repeat (8) @(posedge i_clock);
		i_reset <= 1'b0;

		// Idle state right after reset
		@(negedge i_clock);
		check_equal("reset_ready", 32'd0, 32'(o_ready));
		check_equal("reset_empty", 32'd1, 32'(o_empty));
		check_equal("reset_full", 32'd0, 32'(o_full));

		// A word never written reads back as zero
		read_and_compare(addr_t'(0), 0);

		// Random mix of mostly back-to-back requests with a few idle gaps
		for (int k = 0; k < NUM_RANDOM; k++) begin
			r = $random(seed);
			d = $random(seed);
			a = {28'd0, r[3:0]};
			gap = (r[7:6] == 2'b00) ? int'(r[9:8]) + 1 : 0;
			if (r[5:4] != 2'b00) begin
				write_word(a, d, gap);
			end else begin
				read_and_compare(a, gap);
			end
		end

		// Back-to-back writes until the queue fills
		full_seen = 1'b0;
		for (int k = 0; k < NUM_BURST; k++) begin
			d = $random(seed);
			write_word(addr_t'(k % 16), d, 0);
		end
		check_equal("burst_reaches_full", 32'd1, 32'(full_seen));

		for (int k = 0; k < NUM_READBACK; k++) begin
			read_and_compare(addr_t'(k), 0);
		end

		// Last requests leave a full queue behind
		for (int k = 0; k < NUM_FINAL; k++) begin
			d = $random(seed);
			write_word(addr_t'(k), d, 0);
		end

		waited = 0;
		@(negedge i_clock);
		while (!o_empty) begin
			if (waited >= EMPTY_LIMIT) begin
				abort_run("queue did not drain to empty after the last request");
			end
			waited++;
			@(negedge i_clock);
		end
		for (int k = 0; k < EMPTY_LIMIT; k++) begin
			@(negedge i_clock);
			check_equal("empty_holds", 32'd1, 32'(o_empty));
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/wbuf_pkg.sv
write_buffer/wbuf_fifo.sv
write_buffer/write_buffer.sv
src/bus_memory.sv
src/wbuf_top.sv
verif/wbuf_chk.sv
verif/wbuf_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := wbuf_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
